// File: issue_pkg.sv
package issue_pkg;

localparam int unsigned DEFAULT_ROB_DEPTH = 8;

typedef logic [4:0] reg_addr_t;
typedef logic [2:0] rob_index_t;
typedef logic [1:0] rs_index_t;

// primary opcodes
localparam logic [5:0] OP_SPECIAL = 6'b000000;
localparam logic [5:0] OP_J       = 6'b000010;
localparam logic [5:0] OP_BEQ     = 6'b000100;
localparam logic [5:0] OP_BNE     = 6'b000101;
localparam logic [5:0] OP_ADDIU   = 6'b001001;
localparam logic [5:0] OP_ORI     = 6'b001101;
localparam logic [5:0] OP_LW      = 6'b100011;
localparam logic [5:0] OP_SW      = 6'b101011;

// funct codes under OP_SPECIAL
localparam logic [5:0] FN_MULT = 6'b011000;
localparam logic [5:0] FN_ADDU = 6'b100001;
localparam logic [5:0] FN_SUBU = 6'b100011;

typedef enum logic [2:0] {
	FU_NONE,
	FU_ALU,
	FU_LOAD,
	FU_STORE,
	FU_BRANCH,
	FU_MUL
} fu_t;

typedef struct packed {
	fu_t        fu;
	reg_addr_t  rs1;
	reg_addr_t  rs2;
	reg_addr_t  rd;
	logic [31:0] imm;
	logic       use_imm;
	logic       is_controlflow;
	logic [5:0] opcode;
} decoded_instr_t;

typedef struct packed {
	logic                   busy;
	fu_t                    fu;
	rs_index_t              rs_index;
	rob_index_t             reorder;
	logic [1:0]             operand_ready;
	rob_index_t [1:0]       operand_addr;
	logic [1:0][31:0]       operand_data;
	logic [31:0]            imm;
	logic                   delayslot;
} rs_entry_t;

endpackage

// File: instr_decoder.sv
module instr_decoder import issue_pkg::*; (
	input  logic [31:0]    instr_i,
	output decoded_instr_t decoded_o
);

logic [5:0] opcode;
logic [5:0] funct;
reg_addr_t  rs;
reg_addr_t  rt;
reg_addr_t  rd;
logic [31:0] imm_sext;
logic [31:0] imm_zext;

assign opcode   = instr_i[31:26];
assign funct    = instr_i[5:0];
assign rs       = instr_i[25:21];
assign rt       = instr_i[20:16];
assign rd       = instr_i[15:11];
assign imm_sext = {{16{instr_i[15]}}, instr_i[15:0]};
assign imm_zext = {16'b0, instr_i[15:0]};

always_comb begin
	decoded_o        = '0;
	decoded_o.fu     = FU_NONE;
	decoded_o.opcode = opcode;
	unique case (opcode)
		OP_SPECIAL: begin
			decoded_o.rs1 = rs;
			decoded_o.rs2 = rt;
			if (funct == FN_ADDU || funct == FN_SUBU) begin
				decoded_o.fu = FU_ALU;
				decoded_o.rd = rd;
			end else if (funct == FN_MULT) begin
				// result goes to hi/lo, no gpr destination
				decoded_o.fu = FU_MUL;
			end
		end
		OP_ADDIU, OP_ORI: begin
			decoded_o.fu      = FU_ALU;
			decoded_o.rs1     = rs;
			decoded_o.rd      = rt;
			decoded_o.use_imm = 1'b1;
			decoded_o.imm     = (opcode == OP_ORI) ? imm_zext : imm_sext;
		end
		OP_LW: begin
			decoded_o.fu      = FU_LOAD;
			decoded_o.rs1     = rs;
			decoded_o.rd      = rt;
			decoded_o.use_imm = 1'b1;
			decoded_o.imm     = imm_sext;
		end
		OP_SW: begin
			// operand 1 carries the store data
			decoded_o.fu  = FU_STORE;
			decoded_o.rs1 = rs;
			decoded_o.rs2 = rt;
			decoded_o.imm = imm_sext;
		end
		OP_BEQ, OP_BNE: begin
			decoded_o.fu             = FU_BRANCH;
			decoded_o.rs1            = rs;
			decoded_o.rs2            = rt;
			decoded_o.imm            = imm_sext;
			decoded_o.is_controlflow = 1'b1;
		end
		OP_J: begin
			decoded_o.fu             = FU_BRANCH;
			decoded_o.imm            = {6'b0, instr_i[25:0]};
			decoded_o.is_controlflow = 1'b1;
		end
		default: begin
			decoded_o.fu = FU_NONE;
		end
	endcase
end

endmodule

// File: issue_slot.sv
module issue_slot import issue_pkg::*; (
	input  logic             stall_i,
	input  logic             delayslot_i,
	input  logic             valid_i,
	input  decoded_instr_t   decoded_i,
	input  rob_index_t       reorder_i,
	input  logic [1:0][31:0] rdata_i,
	input  logic [1:0]       rpending_i,
	input  rob_index_t [1:0] rtag_i,

	input  logic             alu_ready_i,
	input  rs_index_t        alu_index_i,
	input  logic             lsu_ready_i,
	input  rs_index_t        lsu_index_i,
	input  logic             branch_ready_i,
	input  rs_index_t        branch_index_i,
	input  logic             mul_ready_i,

	output logic             alu_taken_o,
	output logic             lsu_taken_o,
	output logic             branch_taken_o,
	output logic             mul_taken_o,
	output rs_entry_t        rs_o
);

logic go;
logic is_lsu;
logic taken;

assign go     = valid_i & ~stall_i;
assign is_lsu = (decoded_i.fu == FU_LOAD) || (decoded_i.fu == FU_STORE);

assign alu_taken_o    = go && decoded_i.fu == FU_ALU && alu_ready_i;
assign lsu_taken_o    = go && is_lsu && lsu_ready_i;
assign branch_taken_o = go && decoded_i.fu == FU_BRANCH && branch_ready_i;
assign mul_taken_o    = go && decoded_i.fu == FU_MUL && mul_ready_i;

assign taken = alu_taken_o | lsu_taken_o | branch_taken_o | mul_taken_o;

always_comb begin
	rs_o = '0;
	if (taken) begin
		rs_o.busy      = 1'b1;
		rs_o.fu        = decoded_i.fu;
		rs_o.reorder   = reorder_i;
		rs_o.imm       = decoded_i.imm;
		rs_o.delayslot = delayslot_i;

		// multiplier has a single entry, index stays 0
		if (alu_taken_o)
			rs_o.rs_index = alu_index_i;
		else if (lsu_taken_o)
			rs_o.rs_index = lsu_index_i;
		else if (branch_taken_o)
			rs_o.rs_index = branch_index_i;

		for (int i = 0; i < 2; i++) begin
			rs_o.operand_ready[i] = ~rpending_i[i];
			rs_o.operand_addr[i]  = rtag_i[i];
			rs_o.operand_data[i]  = rdata_i[i];
		end

		// immediate replaces the second source
		if (decoded_i.use_imm)
			rs_o.operand_ready[1] = 1'b1;
	end
end

endmodule

// File: reg_status_table.sv
module reg_status_table import issue_pkg::*; (
	input  logic             clk,
	input  logic             rst_i,
	input  reg_addr_t [3:0]  raddr_i,
	input  logic [1:0]       mark_we_i,
	input  reg_addr_t [1:0]  mark_addr_i,
	input  rob_index_t [1:0] mark_tag_i,
	input  logic             wb_we_i,
	input  reg_addr_t        wb_addr_i,
	input  rob_index_t       wb_reorder_i,
	input  logic [31:0]      wb_data_i,
	output logic [3:0][31:0] rdata_o,
	output logic [3:0]       rpending_o,
	output rob_index_t [3:0] rtag_o
);

logic [31:0] regs [32];
logic [31:0] pending;
rob_index_t  tags [32];
logic        wb_hit;

// writeback only lands when it belongs to the latest rename
assign wb_hit = wb_we_i && wb_addr_i != '0 && pending[wb_addr_i]
	&& tags[wb_addr_i] == wb_reorder_i;

always_ff @(posedge clk) begin
	if (rst_i) begin
		pending <= '0;
		for (int i = 0; i < 32; i++)
			regs[i] <= '0;
	end else begin
		if (wb_hit) begin
			regs[wb_addr_i]    <= wb_data_i;
			pending[wb_addr_i] <= 1'b0;
		end
		// later slot overrides, issue overrides writeback
		for (int i = 0; i < 2; i++) begin
			if (mark_we_i[i] && mark_addr_i[i] != '0)
				pending[mark_addr_i[i]] <= 1'b1;
		end
	end
end

always_ff @(posedge clk) begin
	for (int i = 0; i < 2; i++) begin
		if (mark_we_i[i] && mark_addr_i[i] != '0)
			tags[mark_addr_i[i]] <= mark_tag_i[i];
	end
end

always_comb begin
	for (int i = 0; i < 4; i++) begin
		rtag_o[i] = tags[raddr_i[i]];
		if (raddr_i[i] == '0) begin
			rdata_o[i]    = '0;
			rpending_o[i] = 1'b0;
			rtag_o[i]     = '0;
		end else if (wb_hit && wb_addr_i == raddr_i[i]) begin
			rdata_o[i]    = wb_data_i;
			rpending_o[i] = 1'b0;
		end else begin
			rdata_o[i]    = regs[raddr_i[i]];
			rpending_o[i] = pending[raddr_i[i]];
		end
	end
end

endmodule

// File: rob_alloc.sv
module rob_alloc import issue_pkg::*; #(
	parameter int unsigned ROB_DEPTH = DEFAULT_ROB_DEPTH
) (
	input  logic             clk,
	input  logic             rst_i,
	input  logic [1:0]       issue_count_i,
	input  logic [1:0]       retire_i,
	output rob_index_t [1:0] tag_o,
	output logic             rob_low_o
);

localparam int unsigned CNT_W = $clog2(ROB_DEPTH + 1);

rob_index_t                     tail;
logic [CNT_W-1:0]               count;
logic [$bits(rob_index_t):0]    tail_sum;

assign tag_o[0] = tail;
assign tag_o[1] = (tail == rob_index_t'(ROB_DEPTH - 1)) ? '0 : tail + 1'b1;

// fewer than two free entries left
assign rob_low_o = count > CNT_W'(ROB_DEPTH - 2);

assign tail_sum = tail + issue_count_i;

always_ff @(posedge clk) begin
	if (rst_i) begin
		tail  <= '0;
		count <= '0;
	end else begin
		if (tail_sum >= ROB_DEPTH)
			tail <= rob_index_t'(tail_sum - ROB_DEPTH);
		else
			tail <= rob_index_t'(tail_sum);
		count <= count + CNT_W'(issue_count_i) - CNT_W'(retire_i);
	end
end

endmodule

// File: instr_issue.sv
module instr_issue import issue_pkg::*; (
	input  logic                  [1:0] fetch_valid_i,
	input  decoded_instr_t        [1:0] decoded_i,
	output logic                  [1:0] fetch_ack_o,

	input  logic                  rob_low_i,
	input  rob_index_t            [1:0] rob_tag_i,

	input  logic                  [1:0] alu_ready_i,
	input  rs_index_t             [1:0] alu_index_i,
	output logic                  [1:0] alu_taken_o,
	input  logic                  lsu_locked_i,
	input  logic                  [1:0] lsu_ready_i,
	input  rs_index_t             [1:0] lsu_index_i,
	output logic                  [1:0] lsu_taken_o,
	input  logic                  branch_ready_i,
	input  rs_index_t             branch_index_i,
	output logic                  [1:0] branch_taken_o,
	input  logic                  mul_ready_i,
	output logic                  [1:0] mul_taken_o,
	output rs_entry_t             [1:0] rs_o,

	output reg_addr_t             [3:0] raddr_o,
	input  logic [3:0][31:0]      rdata_i,
	input  logic                  [3:0] rpending_i,
	input  rob_index_t            [3:0] rtag_i,

	output logic                  [1:0] mark_we_o,
	output reg_addr_t             [1:0] mark_addr_o,
	output rob_index_t            [1:0] mark_tag_o,
	output logic                  [1:0] issue_count_o
);

logic            stall;
logic      [1:0] instr_valid;
rs_entry_t [1:0] rs;
logic            alu_ready_1, lsu_ready_1;
rs_index_t       alu_index_1, lsu_index_1;
rob_index_t      reorder_1;
fu_t             fu0, fu1;

assign fu0 = decoded_i[0].fu;
assign fu1 = decoded_i[1].fu;

// a branch waits until its delay slot is fetched
assign stall = rob_low_i | (decoded_i[0].is_controlflow & ~fetch_valid_i[1]);

assign instr_valid[0] = fetch_valid_i[0] && !(fu0 == FU_LOAD && lsu_locked_i);
assign instr_valid[1] = fetch_valid_i[1]
	&& rs[0].busy
	&& !decoded_i[1].is_controlflow
	&& !(fu0 == FU_MUL && fu1 == FU_MUL)
	&& !(fu0 == FU_STORE && fu1 == FU_STORE)
	&& !(fu0 == FU_STORE && fu1 == FU_LOAD)
	&& !(fu1 == FU_LOAD && lsu_locked_i);

issue_slot slot_0_i (
	.stall_i        ( stall              ),
	.delayslot_i    ( 1'b0               ),
	.valid_i        ( instr_valid[0]     ),
	.decoded_i      ( decoded_i[0]       ),
	.reorder_i      ( rob_tag_i[0]       ),
	.rdata_i        ( rdata_i[1:0]       ),
	.rpending_i     ( rpending_i[1:0]    ),
	.rtag_i         ( rtag_i[1:0]        ),
	.alu_ready_i    ( alu_ready_i[0]     ),
	.alu_index_i    ( alu_index_i[0]     ),
	.lsu_ready_i    ( lsu_ready_i[0]     ),
	.lsu_index_i    ( lsu_index_i[0]     ),
	.branch_ready_i ( branch_ready_i     ),
	.branch_index_i ( branch_index_i     ),
	.mul_ready_i    ( mul_ready_i        ),
	.alu_taken_o    ( alu_taken_o[0]     ),
	.lsu_taken_o    ( lsu_taken_o[0]     ),
	.branch_taken_o ( branch_taken_o[0]  ),
	.mul_taken_o    ( mul_taken_o[0]     ),
	.rs_o           ( rs[0]              )
);

// slot 1 may fall back to entry 0 when slot 0 left it free
assign alu_ready_1 = alu_ready_i[1] | (alu_ready_i[0] & ~alu_taken_o[0]);
assign alu_index_1 = alu_ready_i[1] ? alu_index_i[1] : alu_index_i[0];
assign lsu_ready_1 = lsu_ready_i[1] | (lsu_ready_i[0] & ~lsu_taken_o[0]);
assign lsu_index_1 = lsu_ready_i[1] ? lsu_index_i[1] : lsu_index_i[0];
assign reorder_1   = rs[0].busy ? rob_tag_i[1] : rob_tag_i[0];

issue_slot slot_1_i (
	.stall_i        ( stall                     ),
	.delayslot_i    ( decoded_i[0].is_controlflow ),
	.valid_i        ( instr_valid[1]            ),
	.decoded_i      ( decoded_i[1]              ),
	.reorder_i      ( reorder_1                 ),
	.rdata_i        ( rdata_i[3:2]              ),
	.rpending_i     ( rpending_i[3:2]           ),
	.rtag_i         ( rtag_i[3:2]               ),
	.alu_ready_i    ( alu_ready_1               ),
	.alu_index_i    ( alu_index_1               ),
	.lsu_ready_i    ( lsu_ready_1               ),
	.lsu_index_i    ( lsu_index_1               ),
	.branch_ready_i ( 1'b0                      ),
	.branch_index_i ( '0                        ),
	.mul_ready_i    ( mul_ready_i               ),
	.alu_taken_o    ( alu_taken_o[1]            ),
	.lsu_taken_o    ( lsu_taken_o[1]            ),
	.branch_taken_o ( branch_taken_o[1]         ),
	.mul_taken_o    ( mul_taken_o[1]            ),
	.rs_o           ( rs[1]                     )
);

// slot 1 sources written by slot 0 wait on slot 0's tag
always_comb begin
	rs_o = rs;
	if (rs[1].busy && decoded_i[0].rd != '0) begin
		if (decoded_i[0].rd == decoded_i[1].rs1) begin
			rs_o[1].operand_ready[0] = 1'b0;
			rs_o[1].operand_addr[0]  = rs[0].reorder;
		end
		if (!decoded_i[1].use_imm && decoded_i[0].rd == decoded_i[1].rs2) begin
			rs_o[1].operand_ready[1] = 1'b0;
			rs_o[1].operand_addr[1]  = rs[0].reorder;
		end
	end
end

assign issue_count_o = {1'b0, rs[0].busy} + {1'b0, rs[1].busy};
assign fetch_ack_o   = issue_count_o;

for (genvar i = 0; i < 2; i++) begin : gen_ports
	assign raddr_o[i * 2]     = decoded_i[i].rs1;
	assign raddr_o[i * 2 + 1] = decoded_i[i].rs2;

	assign mark_we_o[i]   = rs[i].busy && decoded_i[i].rd != '0;
	assign mark_addr_o[i] = decoded_i[i].rd;
	assign mark_tag_o[i]  = rs[i].reorder;
end

endmodule

// File: issue_top.sv
module issue_top import issue_pkg::*; #(
	parameter int unsigned ROB_DEPTH = DEFAULT_ROB_DEPTH
) (
	input  logic             clk,
	input  logic             rst_i,
	input  logic [1:0]       fetch_valid_i,
	input  logic [1:0][31:0] fetch_instr_i,
	output logic [1:0]       fetch_ack_o,

	input  logic [1:0]       alu_ready_i,
	input  rs_index_t [1:0]  alu_index_i,
	input  logic [1:0]       lsu_ready_i,
	input  rs_index_t [1:0]  lsu_index_i,
	input  logic             lsu_locked_i,
	input  logic             branch_ready_i,
	input  rs_index_t        branch_index_i,
	input  logic             mul_ready_i,
	output logic [1:0]       alu_taken_o,
	output logic [1:0]       lsu_taken_o,
	output logic [1:0]       branch_taken_o,
	output logic [1:0]       mul_taken_o,
	output rs_entry_t [1:0]  rs_o,

	input  logic             wb_we_i,
	input  reg_addr_t        wb_addr_i,
	input  rob_index_t       wb_reorder_i,
	input  logic [31:0]      wb_data_i,
	input  logic [1:0]       retire_i
);

decoded_instr_t [1:0] decoded;
reg_addr_t [3:0]      raddr;
logic [3:0][31:0]     rdata;
logic [3:0]           rpending;
rob_index_t [3:0]     rtag;
logic [1:0]           mark_we;
reg_addr_t [1:0]      mark_addr;
rob_index_t [1:0]     mark_tag;
rob_index_t [1:0]     rob_tag;
logic                 rob_low;
logic [1:0]           issue_count;

for (genvar i = 0; i < 2; i++) begin : gen_decoder
	instr_decoder decoder_i (
		.instr_i   ( fetch_instr_i[i] ),
		.decoded_o ( decoded[i]       )
	);
end

instr_issue issue_i (
	.fetch_valid_i  ( fetch_valid_i  ),
	.decoded_i      ( decoded        ),
	.fetch_ack_o    ( fetch_ack_o    ),
	.rob_low_i      ( rob_low        ),
	.rob_tag_i      ( rob_tag        ),
	.alu_ready_i    ( alu_ready_i    ),
	.alu_index_i    ( alu_index_i    ),
	.alu_taken_o    ( alu_taken_o    ),
	.lsu_locked_i   ( lsu_locked_i   ),
	.lsu_ready_i    ( lsu_ready_i    ),
	.lsu_index_i    ( lsu_index_i    ),
	.lsu_taken_o    ( lsu_taken_o    ),
	.branch_ready_i ( branch_ready_i ),
	.branch_index_i ( branch_index_i ),
	.branch_taken_o ( branch_taken_o ),
	.mul_ready_i    ( mul_ready_i    ),
	.mul_taken_o    ( mul_taken_o    ),
	.rs_o           ( rs_o           ),
	.raddr_o        ( raddr          ),
	.rdata_i        ( rdata          ),
	.rpending_i     ( rpending       ),
	.rtag_i         ( rtag           ),
	.mark_we_o      ( mark_we        ),
	.mark_addr_o    ( mark_addr      ),
	.mark_tag_o     ( mark_tag       ),
	.issue_count_o  ( issue_count    )
);

reg_status_table status_i (
	.clk          ( clk          ),
	.rst_i        ( rst_i        ),
	.raddr_i      ( raddr        ),
	.mark_we_i    ( mark_we      ),
	.mark_addr_i  ( mark_addr    ),
	.mark_tag_i   ( mark_tag     ),
	.wb_we_i      ( wb_we_i      ),
	.wb_addr_i    ( wb_addr_i    ),
	.wb_reorder_i ( wb_reorder_i ),
	.wb_data_i    ( wb_data_i    ),
	.rdata_o      ( rdata        ),
	.rpending_o   ( rpending     ),
	.rtag_o       ( rtag         )
);

rob_alloc #(
	.ROB_DEPTH ( ROB_DEPTH )
) rob_i (
	.clk           ( clk         ),
	.rst_i         ( rst_i       ),
	.issue_count_i ( issue_count ),
	.retire_i      ( retire_i    ),
	.tag_o         ( rob_tag     ),
	.rob_low_o     ( rob_low     )
);

endmodule

// File: issue_sva.sv
module issue_sva (
	input logic       clk_i,
	input logic       stall_i,
	input logic [1:0] fetch_valid_i,
	input logic [1:0] fetch_ack_i,
	input logic [1:0] alu_taken_i,
	input logic [1:0] lsu_taken_i,
	input logic [1:0] branch_taken_i,
	input logic [1:0] mul_taken_i,
	input logic [1:0] busy_i
);

timeunit 1ns;
timeprecision 100ps;

a_quiet_on_stall: assert property (@(posedge clk_i)
	stall_i |-> (fetch_ack_i == '0 && alu_taken_i == '0 && lsu_taken_i == '0
		&& branch_taken_i == '0 && mul_taken_i == '0))
	else $error("unit claimed or fetch acknowledged while stalled");

// cannot consume more than was offered
a_ack_bound: assert property (@(posedge clk_i)
	fetch_ack_i <= $countones(fetch_valid_i))
	else $error("fetch ack exceeds number of valid fetch entries");

a_slot_order: assert property (@(posedge clk_i)
	busy_i[1] |-> busy_i[0])
	else $error("slot 1 issued without slot 0");

endmodule

// File: issue_tb.sv
module issue_tb import issue_pkg::*;;

timeunit 1ns;
timeprecision 100ps;

// tests take about 35 cycles
localparam int unsigned TIMEOUT_CYCLES = 400;

logic             clk;
logic             rst_i;
logic [1:0]       fetch_valid_i;
logic [1:0][31:0] fetch_instr_i;
logic [1:0]       fetch_ack_o;
logic [1:0]       alu_ready_i;
rs_index_t [1:0]  alu_index_i;
logic [1:0]       lsu_ready_i;
rs_index_t [1:0]  lsu_index_i;
logic             lsu_locked_i;
logic             branch_ready_i;
rs_index_t        branch_index_i;
logic             mul_ready_i;
logic [1:0]       alu_taken_o;
logic [1:0]       lsu_taken_o;
logic [1:0]       branch_taken_o;
logic [1:0]       mul_taken_o;
rs_entry_t [1:0]  rs_o;
logic             wb_we_i;
reg_addr_t        wb_addr_i;
rob_index_t       wb_reorder_i;
logic [31:0]      wb_data_i;
logic [1:0]       retire_i;

logic [15:0]      lfsr_state = 16'd93;
int unsigned      cycles = 0;
string            test_name = "reset";

issue_top #(
	.ROB_DEPTH ( 8 )
) dut_i (.*);

bind instr_issue issue_sva sva_i (
	.clk_i          ( issue_tb.clk                     ),
	.stall_i        ( stall                            ),
	.fetch_valid_i  ( fetch_valid_i                    ),
	.fetch_ack_i    ( fetch_ack_o                      ),
	.alu_taken_i    ( alu_taken_o                      ),
	.lsu_taken_i    ( lsu_taken_o                      ),
	.branch_taken_i ( branch_taken_o                   ),
	.mul_taken_i    ( mul_taken_o                      ),
	.busy_i         ( {rs_o[1].busy, rs_o[0].busy}     )
);

initial begin
	clk = 1'b0;
	forever #10 clk = ~clk;
end

always @(posedge clk) begin
	cycles++;
	if (cycles >= TIMEOUT_CYCLES) begin
		$display("timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Test FAILED");
		$fatal(1, "run stopped by cycle limit");
	end
end

// galois lfsr, taps for x^16 + x^14 + x^13 + x^11 + 1
function automatic logic lfsr_bit();
	logic b;
	b = lfsr_state[0];
	lfsr_state = lfsr_state >> 1;
	if (b)
		lfsr_state ^= 16'hb400;
	return b;
endfunction

function automatic logic [31:0] rand_word();
	logic [31:0] w;
	w = '0;
	for (int i = 0; i < 32; i++)
		w = {w[30:0], lfsr_bit()};
	return w;
endfunction

function automatic logic [31:0] r_type(reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
		logic [5:0] funct);
	return {OP_SPECIAL, rs, rt, rd, 5'b0, funct};
endfunction

function automatic logic [31:0] i_type(logic [5:0] op, reg_addr_t rs, reg_addr_t rt,
		logic [15:0] imm);
	return {op, rs, rt, imm};
endfunction

function automatic rs_entry_t make_entry(fu_t fu, rs_index_t idx, rob_index_t tag,
		logic [1:0] rdy, rob_index_t a0, rob_index_t a1, logic [31:0] d0,
		logic [31:0] imm, logic ds);
	rs_entry_t e;
	e                 = '0;
	e.busy            = 1'b1;
	e.fu              = fu;
	e.rs_index        = idx;
	e.reorder         = tag;
	e.operand_ready   = rdy;
	e.operand_addr[0] = a0;
	e.operand_addr[1] = a1;
	e.operand_data[0] = d0;
	e.imm             = imm;
	e.delayslot       = ds;
	return e;
endfunction

task automatic report_mismatch(input string msg);
	$display("** Error @ %0t: [%s] %s", $time, test_name, msg);
	$display("Test FAILED");
	$fatal(1, "stopping at first mismatch");
endtask

task automatic check_ack(input logic [1:0] got, input logic [1:0] exp);
	if (got !== exp)
		report_mismatch($sformatf("fetch_ack_o is %0d, expected %0d", got, exp));
endtask

task automatic check_taken(input logic [1:0] got, input logic [1:0] exp, input string what);
	if (got !== exp)
		report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
endtask

// operand address only matters while waiting, data only once ready
task automatic check_rs(input rs_entry_t got, input rs_entry_t exp, input string what);
	if (!exp.busy) begin
		if (got !== '0)
			report_mismatch($sformatf("%s should be empty, got %h", what, got));
	end else begin
		if (got.busy !== 1'b1 || got.fu !== exp.fu || got.rs_index !== exp.rs_index
				|| got.reorder !== exp.reorder || got.operand_ready !== exp.operand_ready
				|| got.imm !== exp.imm || got.delayslot !== exp.delayslot)
			report_mismatch($sformatf("%s is %h, expected %h", what, got, exp));
		for (int i = 0; i < 2; i++) begin
			if (exp.operand_ready[i] && got.operand_data[i] !== exp.operand_data[i])
				report_mismatch($sformatf("%s operand %0d data %h, expected %h", what, i,
					got.operand_data[i], exp.operand_data[i]));
			if (!exp.operand_ready[i] && got.operand_addr[i] !== exp.operand_addr[i])
				report_mismatch($sformatf("%s operand %0d waits on %0d, expected %0d", what,
					i, got.operand_addr[i], exp.operand_addr[i]));
		end
	end
endtask

// sample mid-cycle, then move to the next drive point
task automatic check_cycle(input logic [1:0] ack, input logic [1:0] alu, input logic [1:0] lsu,
		input logic [1:0] br, input logic [1:0] mul, input rs_entry_t e0, input rs_entry_t e1);
	@(negedge clk);
	check_ack(fetch_ack_o, ack);
	check_taken(alu_taken_o, alu, "alu_taken_o");
	check_taken(lsu_taken_o, lsu, "lsu_taken_o");
	check_taken(branch_taken_o, br, "branch_taken_o");
	check_taken(mul_taken_o, mul, "mul_taken_o");
	check_rs(rs_o[0], e0, "rs_o[0]");
	check_rs(rs_o[1], e1, "rs_o[1]");
	@(posedge clk);
	#2;
endtask

task automatic fetch(input logic [1:0] valid, input logic [31:0] i0, input logic [31:0] i1);
	fetch_valid_i    = valid;
	fetch_instr_i[0] = i0;
	fetch_instr_i[1] = i1;
endtask

task automatic do_reset();
	rst_i          = 1'b1;
	fetch(2'b00, '0, '0);
	alu_ready_i    = 2'b11;
	alu_index_i[0] = 2'd1;
	alu_index_i[1] = 2'd2;
	lsu_ready_i    = 2'b11;
	lsu_index_i[0] = 2'd0;
	lsu_index_i[1] = 2'd3;
	lsu_locked_i   = 1'b0;
	branch_ready_i = 1'b1;
	branch_index_i = 2'd2;
	mul_ready_i    = 1'b1;
	wb_we_i        = 1'b0;
	wb_addr_i      = '0;
	wb_reorder_i   = '0;
	wb_data_i      = '0;
	retire_i       = 2'd0;
	repeat (2) @(posedge clk);
	#2;
	rst_i = 1'b0;
endtask

task automatic test_single();
	test_name = "single";
	do_reset();
	fetch(2'b01, r_type(1, 2, 3, FN_ADDU), '0);
	check_cycle(2'd1, 2'b01, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd0, 2'b11, 0, 0, 0, 0, 0), '0);
	fetch(2'b01, i_type(OP_ADDIU, 0, 4, 16'hfff0), '0);
	check_cycle(2'd1, 2'b01, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd1, 2'b11, 0, 0, 0, 32'hfffffff0, 0), '0);
endtask

task automatic test_pair();
	test_name = "pair";
	do_reset();
	fetch(2'b01, r_type(0, 0, 1, FN_ADDU), '0);
	check_cycle(2'd1, 2'b01, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd0, 2'b11, 0, 0, 0, 0, 0), '0);
	// second reads the first one's rd
	fetch(2'b11, i_type(OP_ADDIU, 0, 5, 16'd7), r_type(5, 0, 6, FN_ADDU));
	check_cycle(2'd2, 2'b11, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd1, 2'b11, 0, 0, 0, 32'd7, 0),
		make_entry(FU_ALU, 2'd2, 3'd2, 2'b10, 3'd1, 0, 0, 0, 0));
endtask

task automatic test_pairing();
	test_name = "pairing";
	do_reset();
	fetch(2'b11, r_type(1, 2, 0, FN_MULT), r_type(3, 4, 0, FN_MULT));
	check_cycle(2'd1, 2'b00, 2'b00, 2'b00, 2'b01,
		make_entry(FU_MUL, 2'd0, 3'd0, 2'b11, 0, 0, 0, 0, 0), '0);
	fetch(2'b11, i_type(OP_SW, 1, 2, 16'd4), i_type(OP_LW, 1, 3, 16'd8));
	check_cycle(2'd1, 2'b00, 2'b01, 2'b00, 2'b00,
		make_entry(FU_STORE, 2'd0, 3'd1, 2'b11, 0, 0, 0, 32'd4, 0), '0);
	lsu_locked_i = 1'b1;
	fetch(2'b01, i_type(OP_LW, 1, 3, 16'd8), '0);
	check_cycle(2'd0, 2'b00, 2'b00, 2'b00, 2'b00, '0, '0);
	lsu_locked_i = 1'b0;
	alu_ready_i  = 2'b00;
	// the load alone would find a free lsu entry
	fetch(2'b11, r_type(1, 2, 3, FN_ADDU), i_type(OP_LW, 1, 4, 16'd8));
	check_cycle(2'd0, 2'b00, 2'b00, 2'b00, 2'b00, '0, '0);
	alu_ready_i = 2'b11;
endtask

task automatic test_scoreboard();
	logic [31:0] wb_val;
	test_name = "scoreboard";
	do_reset();
	fetch(2'b11, r_type(0, 0, 1, FN_ADDU), i_type(OP_ADDIU, 0, 7, 16'd5));
	check_cycle(2'd2, 2'b11, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd0, 2'b11, 0, 0, 0, 0, 0),
		make_entry(FU_ALU, 2'd2, 3'd1, 2'b11, 0, 0, 0, 32'd5, 0));
	fetch(2'b01, r_type(7, 0, 8, FN_ADDU), '0);
	check_cycle(2'd1, 2'b01, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd2, 2'b10, 3'd1, 0, 0, 0, 0), '0);
	// matching writeback, forwarded in the same cycle
	wb_val       = rand_word();
	wb_we_i      = 1'b1;
	wb_addr_i    = 5'd7;
	wb_reorder_i = 3'd1;
	wb_data_i    = wb_val;
	fetch(2'b01, r_type(7, 0, 9, FN_ADDU), '0);
	check_cycle(2'd1, 2'b01, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd3, 2'b11, 0, 0, wb_val, 0, 0), '0);
	// stale tag for r8
	wb_addr_i    = 5'd8;
	wb_reorder_i = 3'd5;
	wb_data_i    = rand_word();
	fetch(2'b01, r_type(7, 8, 10, FN_ADDU), '0);
	check_cycle(2'd1, 2'b01, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd4, 2'b01, 0, 3'd2, wb_val, 0, 0), '0);
	wb_we_i = 1'b0;
	fetch(2'b01, r_type(8, 0, 11, FN_ADDU), '0);
	check_cycle(2'd1, 2'b01, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd5, 2'b10, 3'd2, 0, 0, 0, 0), '0);
endtask

task automatic test_rob_full();
	test_name = "rob_full";
	do_reset();
	for (int k = 0; k < 3; k++) begin
		fetch(2'b11, r_type(0, 0, 1, FN_ADDU), r_type(0, 0, 2, FN_ADDU));
		check_cycle(2'd2, 2'b11, 2'b00, 2'b00, 2'b00,
			make_entry(FU_ALU, 2'd1, rob_index_t'(2 * k), 2'b11, 0, 0, 0, 0, 0),
			make_entry(FU_ALU, 2'd2, rob_index_t'(2 * k + 1), 2'b11, 0, 0, 0, 0, 0));
	end
	fetch(2'b01, r_type(0, 0, 1, FN_ADDU), '0);
	check_cycle(2'd1, 2'b01, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd6, 2'b11, 0, 0, 0, 0, 0), '0);
	// one entry left, stalled
	fetch(2'b11, r_type(0, 0, 1, FN_ADDU), r_type(0, 0, 2, FN_ADDU));
	retire_i = 2'd2;
	check_cycle(2'd0, 2'b00, 2'b00, 2'b00, 2'b00, '0, '0);
	retire_i = 2'd0;
	check_cycle(2'd2, 2'b11, 2'b00, 2'b00, 2'b00,
		make_entry(FU_ALU, 2'd1, 3'd7, 2'b11, 0, 0, 0, 0, 0),
		make_entry(FU_ALU, 2'd2, 3'd0, 2'b11, 0, 0, 0, 0, 0));
endtask

task automatic test_control_flow();
	test_name = "control_flow";
	do_reset();
	fetch(2'b01, i_type(OP_BEQ, 1, 2, 16'd3), '0);
	check_cycle(2'd0, 2'b00, 2'b00, 2'b00, 2'b00, '0, '0);
	fetch(2'b11, i_type(OP_BEQ, 1, 2, 16'd3), r_type(1, 2, 3, FN_ADDU));
	check_cycle(2'd2, 2'b10, 2'b00, 2'b01, 2'b00,
		make_entry(FU_BRANCH, 2'd2, 3'd0, 2'b11, 0, 0, 0, 32'd3, 0),
		make_entry(FU_ALU, 2'd2, 3'd1, 2'b11, 0, 0, 0, 0, 1));
	fetch(2'b11, i_type(OP_BEQ, 1, 2, 16'd3), i_type(OP_BEQ, 4, 5, 16'd1));
	check_cycle(2'd1, 2'b00, 2'b00, 2'b01, 2'b00,
		make_entry(FU_BRANCH, 2'd2, 3'd2, 2'b11, 0, 0, 0, 32'd3, 0), '0);
endtask

initial begin
	test_single();
	test_pair();
	test_pairing();
	test_scoreboard();
	test_rob_full();
	test_control_flow();
	$display("Test OK");
	$finish;
end

endmodule

// File: issue_top.f
issue_pkg.sv
instr_decoder.sv
issue_slot.sv
reg_status_table.sv
rob_alloc.sv
instr_issue.sv
issue_top.sv
issue_sva.sv
issue_tb.sv

// File: Bender.yml
package:
  name: issue_top

sources:
  - issue_pkg.sv
  - instr_decoder.sv
  - issue_slot.sv
  - reg_status_table.sv
  - rob_alloc.sv
  - instr_issue.sv
  - issue_top.sv
  - target: test
    files:
      - issue_sva.sv
      - issue_tb.sv
